// File: flist.f
src/loader_pkg.sv
src/byte_packer.sv
src/word_fifo.sv
src/mem_port_mux.sv
src/word_ram.sv
src/loader_top.sv
verif/loader_tb.sv

// File: run.sh
#!/bin/sh
# build the loader testbench with verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module loader_tb -Mdir obj_dir -o loader_sim \
	-f flist.f \
	&& ./obj_dir/loader_sim > sim.log 2>&1 \
	|| { echo "build or run failed"; exit 1; }
cat sim.log
grep -qx ">>> PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: verif/loader_tb.sv
`default_nettype none

module loader_tb;

	localparam logic [loader_pkg::ADDR_W-1:0] START_ADDR = 24'h000040;
	localparam int FIFO_DEPTH = 4;
	localparam int RAM_AW = 8;
	localparam int TIMEOUT_CYC = 200;
	// word address of the first loaded word
	localparam logic [loader_pkg::WORD_AW-1:0] BASE_WADDR =
		START_ADDR[loader_pkg::ADDR_W-1:2];

	logic clk_32m = 1'b0;
	logic rst_n_i;
	logic dl_active;
	logic dl_stb;
	logic [7:0] dl_data;
	loader_pkg::mem_req_t core_req;
	logic core_ack;
	logic [loader_pkg::DATA_W-1:0] core_rdata;
	logic loading;

	integer seed;
	int errors;
	int checks;
	int test_errors;
	int tests_run;
	int tests_failed;
	int acks_in_load;
	string cur_test;
	// bytes of the current download in send order
	logic [7:0] sent_q [$];
	logic [loader_pkg::DATA_W-1:0] first_words [16];

	loader_top #(
		.START_ADDR(START_ADDR),
		.FIFO_DEPTH(FIFO_DEPTH),
		.RAM_AW(RAM_AW)
	) dut_i (
		.clk_32m(clk_32m),
		.rst_n_i(rst_n_i),
		.dl_active_i(dl_active),
		.dl_stb_i(dl_stb),
		.dl_data_i(dl_data),
		.core_req_i(core_req),
		.core_ack_o(core_ack),
		.core_rdata_o(core_rdata),
		.loading_o(loading)
	);

	always #5 clk_32m = ~clk_32m;

	// core acks that slip through while a load is busy
	always @(posedge clk_32m) begin
		if (!rst_n_i) begin
			acks_in_load <= 0;
		end else if (core_ack && loading) begin
			acks_in_load <= acks_in_load + 1;
		end
	end

	task automatic check_word(input string what, input logic [loader_pkg::DATA_W-1:0] exp,
		input logic [loader_pkg::DATA_W-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			test_errors++;
			$display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			test_errors++;
			$display("ERR %s %s: expected %b, actual %b", cur_test, what, exp, act);
		end
	endtask

	// timeouts and other non-value failures
	task automatic report_failure(input string text);
		errors++;
		test_errors++;
		$display("%s failed: %s", cur_test, text);
	endtask

	task automatic open_test(input string name);
		cur_test = name;
		test_errors = 0;
	endtask

	task automatic close_test();
		tests_run++;
		if (test_errors == 0) begin
			$display("%s finished, all checks ok", cur_test);
		end else begin
			tests_failed++;
			$display("%s finished with %0d errors", cur_test, test_errors);
		end
	endtask

	function automatic logic [loader_pkg::WORD_AW-1:0] word_addr(input int w);
		return BASE_WADDR + w[loader_pkg::WORD_AW-1:0];
	endfunction

	// byte at the lowest address lands in lane 0
	function automatic logic [loader_pkg::DATA_W-1:0] sent_word(input int w);
		return {sent_q[4*w+3], sent_q[4*w+2], sent_q[4*w+1], sent_q[4*w]};
	endfunction

	// strobe period picked between min_gap and max_gap cycles
	task automatic send_bytes(input int count, input int min_gap, input int max_gap);
		logic [31:0] r;
		int gap;
		if (!dl_active) begin
			@(posedge clk_32m);
			dl_active <= 1'b1;
		end
		for (int n = 0; n < count; n++) begin
			@(posedge clk_32m);
			r = $random(seed);
			dl_stb <= 1'b1;
			dl_data <= r[7:0];
			sent_q.push_back(r[7:0]);
			gap = min_gap + (r[15:8] % (max_gap - min_gap + 1));
			// gap of 1 keeps the strobe high
			for (int k = 1; k < gap; k++) begin
				@(posedge clk_32m);
				dl_stb <= 1'b0;
			end
		end
		@(posedge clk_32m);
		dl_stb <= 1'b0;
	endtask

	task automatic end_download();
		@(posedge clk_32m);
		dl_active <= 1'b0;
		dl_stb <= 1'b0;
	endtask

	// falling loading_o marks the last ram write
	task automatic wait_load_done();
		int cycles;
		cycles = 0;
		@(posedge clk_32m);
		while (loading && cycles < TIMEOUT_CYC) begin
			@(posedge clk_32m);
			cycles++;
		end
		if (loading) begin
			report_failure("loading_o did not fall after the download ended");
		end
	endtask

	// stb held until the ack is seen
	task automatic core_access(input logic we, input logic [3:0] sel,
		input logic [loader_pkg::WORD_AW-1:0] addr,
		input logic [loader_pkg::DATA_W-1:0] wdata,
		output logic [loader_pkg::DATA_W-1:0] rdata, output logic acked);
		int cycles;
		acked = 1'b0;
		rdata = '0;
		cycles = 0;
		@(posedge clk_32m);
		core_req.stb <= 1'b1;
		core_req.we <= we;
		core_req.sel <= sel;
		core_req.addr <= addr;
		core_req.wdata <= wdata;
		while (!acked && cycles < TIMEOUT_CYC) begin
			@(posedge clk_32m);
			cycles++;
			if (core_ack) begin
				acked = 1'b1;
				// read data valid in the ack cycle
				rdata = core_rdata;
			end
		end
		core_req.stb <= 1'b0;
		if (!acked) begin
			report_failure("core access got no core_ack_o before the timeout");
		end
	endtask

	task automatic core_write(input logic [loader_pkg::WORD_AW-1:0] addr, input logic [3:0] sel,
		input logic [loader_pkg::DATA_W-1:0] data);
		logic [loader_pkg::DATA_W-1:0] unused;
		logic acked;
		core_access(1'b1, sel, addr, data, unused, acked);
		check_bit("core write ack", 1'b1, acked);
	endtask

	task automatic core_read(input logic [loader_pkg::WORD_AW-1:0] addr,
		output logic [loader_pkg::DATA_W-1:0] data);
		logic acked;
		core_access(1'b0, 4'hf, addr, '0, data, acked);
		check_bit("core read ack", 1'b1, acked);
	endtask

	task automatic reset_state();
		logic [loader_pkg::DATA_W-1:0] rd;
		open_test("reset_state");
		@(posedge clk_32m);
		check_bit("loading_o", 1'b0, loading);
		check_bit("core_ack_o", 1'b0, core_ack);
		// ram contents still unknown here
		core_read(word_addr(40), rd);
		close_test();
	endtask

	task automatic full_word_load();
		logic [loader_pkg::DATA_W-1:0] rd;
		open_test("full_word_load");
		sent_q.delete();
		send_bytes(16, 2, 5);
		end_download();
		wait_load_done();
		for (int w = 0; w < 4; w++) begin
			core_read(word_addr(w), rd);
			check_word($sformatf("word %0d", w), sent_word(w), rd);
		end
		close_test();
	endtask

	task automatic partial_flush();
		logic [loader_pkg::DATA_W-1:0] rd;
		open_test("partial_flush");
		// word 2 takes the two trailing bytes
		core_write(word_addr(2), 4'hf, 32'hffffffff);
		sent_q.delete();
		send_bytes(10, 1, 3);
		end_download();
		wait_load_done();
		for (int w = 0; w < 2; w++) begin
			core_read(word_addr(w), rd);
			check_word($sformatf("word %0d", w), sent_word(w), rd);
		end
		core_read(word_addr(2), rd);
		// upper lanes untouched by the flush
		check_word("flush word", {16'hffff, sent_q[9], sent_q[8]}, rd);
		close_test();
	endtask

	task automatic core_blocked_during_load();
		logic [loader_pkg::DATA_W-1:0] value;
		logic [loader_pkg::DATA_W-1:0] rd;
		logic acked;
		logic loading_at_ack;
		int base_acks;
		int cycles;
		open_test("core_blocked_during_load");
		value = $random(seed);
		base_acks = acks_in_load;
		sent_q.delete();
		send_bytes(4, 2, 2);
		// core write raised mid download
		@(posedge clk_32m);
		core_req.stb <= 1'b1;
		core_req.we <= 1'b1;
		core_req.sel <= 4'hf;
		core_req.addr <= word_addr(100);
		core_req.wdata <= value;
		send_bytes(4, 2, 2);
		// last word still in flight when the level drops
		end_download();
		acked = 1'b0;
		loading_at_ack = 1'b1;
		cycles = 0;
		while (!acked && cycles < TIMEOUT_CYC) begin
			@(posedge clk_32m);
			cycles++;
			if (core_ack) begin
				acked = 1'b1;
				loading_at_ack = loading;
			end
		end
		core_req.stb <= 1'b0;
		if (!acked) begin
			report_failure("held core write was never acknowledged");
		end
		check_bit("loading_o at core ack", 1'b0, loading_at_ack);
		@(posedge clk_32m);
		check_bit("core_ack_o one cycle later", 1'b0, core_ack);
		check_bit("core ack seen while loading", 1'b0, acks_in_load != base_acks);
		core_read(word_addr(100), rd);
		check_word("core written word", value, rd);
		for (int w = 0; w < 2; w++) begin
			core_read(word_addr(w), rd);
			check_word($sformatf("word %0d", w), sent_word(w), rd);
		end
		close_test();
	endtask

	task automatic restart_at_full_rate();
		logic [loader_pkg::DATA_W-1:0] rd;
		open_test("restart_at_full_rate");
		sent_q.delete();
		send_bytes(64, 1, 1);
		end_download();
		wait_load_done();
		for (int w = 0; w < 16; w++) begin
			first_words[w] = sent_word(w);
		end
		// second download starts over at the base word
		sent_q.delete();
		send_bytes(8, 1, 1);
		end_download();
		wait_load_done();
		for (int w = 0; w < 16; w++) begin
			core_read(word_addr(w), rd);
			if (w < 2) begin
				check_word($sformatf("second load word %0d", w), sent_word(w), rd);
			end else begin
				check_word($sformatf("first load word %0d", w), first_words[w], rd);
			end
		end
		close_test();
	endtask

	initial begin
		seed = 32'hf143d208;
		errors = 0;
		checks = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		rst_n_i <= 1'b0;
		dl_active <= 1'b0;
		dl_stb <= 1'b0;
		dl_data <= '0;
		core_req <= '0;
		// synchronous reset over two rising edges
		repeat (2) @(posedge clk_32m);
		rst_n_i <= 1'b1;
		reset_state();
		full_word_load();
		partial_flush();
		core_blocked_during_load();
		restart_at_full_rate();
		$display("%0d tests run, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// last resort if a wait loop itself gets stuck
	initial begin
		#100000;
		$display("simulation watchdog expired before the tests finished");
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/loader_top.sv
`default_nettype none

module loader_top #(
	parameter logic [loader_pkg::ADDR_W-1:0] START_ADDR = 24'h000040,
	parameter int FIFO_DEPTH = 4,
	parameter int RAM_AW = 8
) (
	input wire logic clk_32m,
	input wire logic rst_n_i,
	// download stream
	input wire logic dl_active_i,
	input wire logic dl_stb_i,
	input wire logic [7:0] dl_data_i,
	// core memory port
	input wire loader_pkg::mem_req_t core_req_i,
	output logic core_ack_o,
	output logic [loader_pkg::DATA_W-1:0] core_rdata_o,
	output logic loading_o
);

	// packer to queue
	logic push;
	loader_pkg::load_word_t push_word;

	// queue to port mux
	logic pop;
	logic empty;
	loader_pkg::load_word_t head_word;

	// port mux to ram
	loader_pkg::mem_req_t ram_req;
	logic ram_ack;
	logic [loader_pkg::DATA_W-1:0] ram_rdata;

	byte_packer #(
		.START_ADDR(START_ADDR)
	) packer_i (
		.clk_32m(clk_32m),
		.rst_n_i(rst_n_i),
		.dl_active_i(dl_active_i),
		.dl_stb_i(dl_stb_i),
		.dl_data_i(dl_data_i),
		.push_o(push),
		.word_o(push_word)
	);

	word_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) fifo_i (
		.clk_32m(clk_32m),
		.rst_n_i(rst_n_i),
		.push_i(push),
		.word_i(push_word),
		.pop_i(pop),
		.head_o(head_word),
		.empty_o(empty)
	);

	mem_port_mux mux_i (
		.clk_32m(clk_32m),
		.rst_n_i(rst_n_i),
		.dl_active_i(dl_active_i),
		.head_i(head_word),
		.empty_i(empty),
		.pop_o(pop),
		.core_req_i(core_req_i),
		.core_ack_o(core_ack_o),
		.core_rdata_o(core_rdata_o),
		.ram_req_o(ram_req),
		.ram_ack_i(ram_ack),
		.ram_rdata_i(ram_rdata),
		.loading_o(loading_o)
	);

	// stands in for the sdram port
	word_ram #(
		.RAM_AW(RAM_AW)
	) ram_i (
		.clk_32m(clk_32m),
		.rst_n_i(rst_n_i),
		.req_i(ram_req),
		.ack_o(ram_ack),
		.rdata_o(ram_rdata)
	);

endmodule

`default_nettype wire

// File: src/word_ram.sv
`default_nettype none

module word_ram #(
	parameter int RAM_AW = 8
) (
	input wire logic clk_32m,
	input wire logic rst_n_i,
	input wire loader_pkg::mem_req_t req_i,
	output logic ack_o,
	output logic [loader_pkg::DATA_W-1:0] rdata_o
);

	logic [loader_pkg::DATA_W-1:0] mem_q [2**RAM_AW];

	// stb already answered, still held by the requester
	logic served_q;
	logic req_new;
	logic [RAM_AW-1:0] idx;

	// upper word address bits ignored
	assign idx = req_i.addr[RAM_AW-1:0];
	assign req_new = req_i.stb & ~served_q;

	always_ff @(posedge clk_32m) begin
		if (!rst_n_i) begin
			ack_o <= 1'b0;
			served_q <= 1'b0;
		end else begin
			// single cycle ack per stb
			ack_o <= req_new;
			// cleared once stb drops for a cycle
			served_q <= req_i.stb;
		end
	end

	// write lands on the ack edge
	// read data returned with the ack
	always_ff @(posedge clk_32m) begin
		if (req_new) begin
			if (req_i.we) begin
				for (int n = 0; n < loader_pkg::SEL_W; n++) begin
					if (req_i.sel[n]) begin
						mem_q[idx][8*n +: 8] <= req_i.wdata[8*n +: 8];
					end
				end
			end
			rdata_o <= mem_q[idx];
		end
	end

endmodule

`default_nettype wire

// File: src/mem_port_mux.sv
`default_nettype none

module mem_port_mux (
	input wire logic clk_32m,
	input wire logic rst_n_i,
	input wire logic dl_active_i,
	input wire loader_pkg::load_word_t head_i,
	input wire logic empty_i,
	output logic pop_o,
	input wire loader_pkg::mem_req_t core_req_i,
	output logic core_ack_o,
	output logic [loader_pkg::DATA_W-1:0] core_rdata_o,
	output loader_pkg::mem_req_t ram_req_o,
	input wire logic ram_ack_i,
	input wire logic [loader_pkg::DATA_W-1:0] ram_rdata_i,
	output logic loading_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_CORE
	} state_t;

	state_t state_q;
	state_t state_d;

	// download level history
	// covers the flush word still on its way to the queue
	logic dl_d1_q;
	logic dl_d2_q;

	// registered load write request
	logic load_stb_q;
	loader_pkg::load_word_t load_q;
	loader_pkg::mem_req_t load_req;

	// ram follows the core
	logic core_path;

	// busy from the first level cycle until queue and port drain
	assign loading_o = dl_active_i | dl_d1_q | dl_d2_q | ~empty_i | (state_q == ST_LOAD);

	// take the head word straight from idle
	assign pop_o = (state_q == ST_IDLE) & loading_o & ~empty_i;

	// an access already in flight keeps the port
	assign core_path = (state_q == ST_CORE) | ((state_q == ST_IDLE) & ~loading_o);

	// core never sees a load ack
	assign core_ack_o = (state_q == ST_CORE) & ram_ack_i;
	assign core_rdata_o = ram_rdata_i;

	always_comb begin
		// load stb already low in the ack cycle
		// a core stb held behind the load is then seen as new
		load_req.stb = load_stb_q & ~ram_ack_i;
		load_req.we = 1'b1;
		load_req.sel = load_q.sel;
		load_req.addr = load_q.addr;
		load_req.wdata = load_q.data;
		ram_req_o = core_path ? core_req_i : load_req;
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				// core waits with stb held while loading
				if (loading_o) begin
					if (!empty_i) begin
						state_d = ST_LOAD;
					end
				end else if (core_req_i.stb) begin
					state_d = ST_CORE;
				end
			end
			ST_LOAD: begin
				if (ram_ack_i) begin
					state_d = ST_IDLE;
				end
			end
			ST_CORE: begin
				if (ram_ack_i) begin
					state_d = ST_IDLE;
				end
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_32m) begin
		if (!rst_n_i) begin
			state_q <= ST_IDLE;
			dl_d1_q <= 1'b0;
			dl_d2_q <= 1'b0;
			load_stb_q <= 1'b0;
		end else begin
			state_q <= state_d;
			dl_d1_q <= dl_active_i;
			dl_d2_q <= dl_d1_q;
			// stb rises with the pop and clears after the ack
			if (pop_o) begin
				load_stb_q <= 1'b1;
			end else if (ram_ack_i && (state_q == ST_LOAD)) begin
				load_stb_q <= 1'b0;
			end
		end
	end

	// popped head becomes the write request
	always_ff @(posedge clk_32m) begin
		if (pop_o) begin
			load_q <= head_i;
		end
	end

endmodule

`default_nettype wire

// File: src/word_fifo.sv
`default_nettype none

module word_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input wire logic clk_32m,
	input wire logic rst_n_i,
	input wire logic push_i,
	input wire loader_pkg::load_word_t word_i,
	input wire logic pop_i,
	output loader_pkg::load_word_t head_o,
	output logic empty_o
);

	// depth is a power of two, pointers wrap by themselves
	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(FIFO_DEPTH);

	loader_pkg::load_word_t mem_q [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [PTR_W:0] count_q;

	logic do_push;
	logic do_pop;

	// never fills in one download, guard anyway
	assign do_push = push_i & (count_q != FULL_CNT);
	// pop on empty ignored
	assign do_pop = pop_i & ~empty_o;

	// head shown straight from the array
	assign head_o = mem_q[rd_ptr_q];
	assign empty_o = (count_q == '0);

	always_ff @(posedge clk_32m) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			// push and pop together keep the count
			case ({do_push, do_pop})
				2'b10: begin
					count_q <= count_q + 1'b1;
				end
				2'b01: begin
					count_q <= count_q - 1'b1;
				end
				default: begin
					count_q <= count_q;
				end
			endcase
		end
	end

	// storage, no reset
	always_ff @(posedge clk_32m) begin
		if (do_push) begin
			mem_q[wr_ptr_q] <= word_i;
		end
	end

endmodule

`default_nettype wire

// File: src/byte_packer.sv
`default_nettype none

module byte_packer #(
	parameter logic [loader_pkg::ADDR_W-1:0] START_ADDR = '0
) (
	input wire logic clk_32m,
	input wire logic rst_n_i,
	input wire logic dl_active_i,
	input wire logic dl_stb_i,
	input wire logic [7:0] dl_data_i,
	output logic push_o,
	output loader_pkg::load_word_t word_o
);

	// first word address of every download
	localparam logic [loader_pkg::WORD_AW-1:0] START_WADDR =
		START_ADDR[loader_pkg::ADDR_W-1:2];

	logic dl_active_q;
	logic [1:0] lane_q;
	logic [loader_pkg::DATA_W-1:0] shift_q;
	logic [loader_pkg::WORD_AW-1:0] waddr_q;

	logic dl_rise;
	logic dl_fall;
	logic take_byte;
	logic full_word;
	logic flush_word;
	logic [1:0] lane_base;
	logic [loader_pkg::WORD_AW-1:0] waddr_base;
	logic [loader_pkg::DATA_W-1:0] shift_nxt;
	logic [loader_pkg::SEL_W-1:0] flush_sel;
	logic [loader_pkg::DATA_W-1:0] flush_data;

	// start and end of a download from the held level
	assign dl_rise = dl_active_i & ~dl_active_q;
	assign dl_fall = ~dl_active_i & dl_active_q;
	// strobes outside the level are dropped
	assign take_byte = dl_active_i & dl_stb_i;
	// a new download counts from lane 0 and START_ADDR
	assign lane_base = dl_rise ? 2'd0 : lane_q;
	assign waddr_base = dl_rise ? START_WADDR : waddr_q;
	// new byte enters at the top, older bytes move down
	assign shift_nxt = {dl_data_i, shift_q[loader_pkg::DATA_W-1:8]};
	assign full_word = take_byte & (lane_base == 2'd3);
	// leftover bytes when the level drops
	assign flush_word = dl_fall & (lane_q != 2'd0);

	// partial word moved down to lane 0, top lanes zero
	always_comb begin
		case (lane_q)
			2'd1: begin
				flush_sel = 4'b0001;
				flush_data = {24'd0, shift_q[31:24]};
			end
			2'd2: begin
				flush_sel = 4'b0011;
				flush_data = {16'd0, shift_q[31:16]};
			end
			2'd3: begin
				flush_sel = 4'b0111;
				flush_data = {8'd0, shift_q[31:8]};
			end
			default: begin
				flush_sel = 4'b0000;
				flush_data = '0;
			end
		endcase
	end

	always_ff @(posedge clk_32m) begin
		if (!rst_n_i) begin
			dl_active_q <= 1'b0;
			lane_q <= 2'd0;
			waddr_q <= START_WADDR;
			push_o <= 1'b0;
		end else begin
			dl_active_q <= dl_active_i;
			push_o <= full_word | flush_word;
			if (dl_rise) begin
				lane_q <= 2'd0;
				waddr_q <= START_WADDR;
			end
			if (take_byte) begin
				lane_q <= lane_base + 2'd1;
				// fourth lane filled, next word address
				if (full_word) begin
					waddr_q <= waddr_base + 1'b1;
				end
			end else if (flush_word) begin
				lane_q <= 2'd0;
				waddr_q <= waddr_q + 1'b1;
			end
		end
	end

	// payload only, qualified by push_o
	always_ff @(posedge clk_32m) begin
		if (take_byte) begin
			shift_q <= shift_nxt;
		end
		if (full_word) begin
			word_o.addr <= waddr_base;
			word_o.sel <= 4'b1111;
			word_o.data <= shift_nxt;
		end else if (flush_word) begin
			word_o.addr <= waddr_q;
			word_o.sel <= flush_sel;
			word_o.data <= flush_data;
		end
	end

endmodule

`default_nettype wire

// File: src/loader_pkg.sv
`default_nettype none

package loader_pkg;

	// byte address width of the download path
	localparam int ADDR_W = 24;

	// ram side works on 32-bit words
	localparam int WORD_AW = ADDR_W - 2;

	// data word and byte lanes
	localparam int DATA_W = 32;
	localparam int SEL_W = DATA_W / 8;

	// one request on the strobe/ack memory port
	// stb stays high until the one-cycle ack
	typedef struct packed {
		logic stb;
		logic we;
		// lane n covers wdata[8n+7:8n]
		logic [SEL_W-1:0] sel;
		// word address, byte offset dropped
		logic [WORD_AW-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} mem_req_t;

	// one packed download word on its way to ram
	typedef struct packed {
		logic [WORD_AW-1:0] addr;
		// only received lanes set on a flush word
		logic [SEL_W-1:0] sel;
		// byte 0 of the word in lane 0
		logic [DATA_W-1:0] data;
	} load_word_t;

endpackage

`default_nettype wire
